/* include/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch frontend configuration.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Instructions per fetch block (2, 4 or 8).
`define FETCH_WIDTH   4

`define LINE_BITS     256          // 8 words per cache line.

// First fetch address out of reset.
`define RESET_VECTOR  32'h1eceb000

`endif

/* rtl/fetch_pkg.sv */
`include "fetch_cfg.svh"

package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction cache port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                       read;     // One-cycle strobe.
        logic [31:0]                addr;     // Line aligned.
    } icache_req_t;

    typedef struct packed {
        logic                       resp;     // One-cycle pulse.
        logic [`LINE_BITS-1:0]      rdata;
    } icache_rsp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch FIFO packet.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [31:0]                            pc;
        logic [`FETCH_WIDTH-1:0][31:0]          inst;
        logic [`FETCH_WIDTH-1:0][31:0]          predict_target;
        logic [`FETCH_WIDTH-1:0]                predict_taken;
        // Slots before a mid-block entry point are invalid.
        logic [`FETCH_WIDTH-1:0]                slot_valid;
    } fetch_packet_t;

endpackage

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module fetch_pc_gen (
    input  logic         clk,
    input  logic         prev_rst,

    input  logic         flush,
    input  logic [31:0]  redirect_pc,
    input  logic         advance,

    output logic [31:0]  pc_next
);

    localparam int unsigned BLK_BYTES = `FETCH_WIDTH * 4;
    localparam logic [31:0] BLK_MASK = ~32'(BLK_BYTES - 1);

    logic [31:0] pc;                        // Block being fetched.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next PC select. Flush wins over sequential stepping.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (prev_rst) begin
            pc_next = `RESET_VECTOR;
        end else if (flush) begin
            pc_next = redirect_pc;
        end else if (advance) begin
            pc_next = (pc + 32'(BLK_BYTES)) & BLK_MASK;   // Next aligned block.
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            pc <= `RESET_VECTOR;
        end else if (advance || flush) begin
            pc <= pc_next;
        end
    end

    // Backend redirects must stay on instruction boundaries.
    a_pc_next_aligned: assert property (
        @(posedge clk) disable iff (prev_rst)
        pc_next[1:0] == 2'b00
    ) else $error("pc_next misaligned: %h", pc_next);

endmodule

/* rtl/fetch_line_reader.sv */
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module fetch_line_reader (
    input  logic                   clk,
    input  logic                   prev_rst,

    input  logic                   flush,
    input  logic [31:0]            pc_next,

    output fetch_pkg::icache_req_t icache_req,
    input  fetch_pkg::icache_rsp_t icache_rsp,

    output logic                   advance,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`LINE_BITS-1:0]  line,
    output logic [31:0]            line_pc
);

    localparam int LINE_OFF = $clog2(`LINE_BITS / 8);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DISCARD,                         // Stale response still due.
        ST_HOLD
    } state_t;

    state_t      state;
    state_t      state_d;
    logic        issue;
    logic [31:0] req_pc;
    logic        outstanding;               // Read sent, resp not back yet.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshakes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign out_valid = (state == ST_HOLD) && !flush;        // Flush drops the packet.
    assign advance   = out_valid && out_ready;

    // Held idle during reset, so nothing goes out to the cache.
    assign issue = !prev_rst && ((state == ST_IDLE) || advance);

    assign icache_req.read = issue;
    assign icache_req.addr = {pc_next[31:LINE_OFF], LINE_OFF'(0)};

    always_comb begin
        state_d = state;
        case (state)
            ST_IDLE: begin
                if (issue) state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (icache_rsp.resp) begin
                    state_d = flush ? ST_IDLE : ST_HOLD;
                end else if (flush) begin
                    state_d = ST_DISCARD;
                end
            end
            ST_DISCARD: begin
                if (icache_rsp.resp) state_d = ST_IDLE;   // Throw the line away.
            end
            ST_HOLD: begin
                if (flush) begin
                    state_d = ST_IDLE;
                end else if (issue) begin
                    state_d = ST_WAIT;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_d;
        end
    end

    // Line and its PC.
    always_ff @(posedge clk) begin
        if (issue) begin
            req_pc <= pc_next;
        end
        if (state == ST_WAIT && icache_rsp.resp) begin
            line    <= icache_rsp.rdata;
            line_pc <= req_pc;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Protocol checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Tracked from the cache port alone.
    always_ff @(posedge clk) begin
        if (prev_rst) begin
            outstanding <= 1'b0;
        end else if (icache_req.read) begin
            outstanding <= 1'b1;
        end else if (icache_rsp.resp) begin
            outstanding <= 1'b0;
        end
    end

    a_one_outstanding: assert property (
        @(posedge clk) disable iff (prev_rst)
        outstanding |-> !icache_req.read
    ) else $error("read issued with a request outstanding");

    a_hold_stable: assert property (
        @(posedge clk) disable iff (prev_rst)
        out_valid && !out_ready |=>
            flush || (out_valid && $stable(line) && $stable(line_pc))
    ) else $error("packet changed under back-pressure");

    a_no_idle_resp: assert property (
        @(posedge clk) disable iff (prev_rst)
        state == ST_IDLE |-> !icache_rsp.resp
    ) else $error("cache response with no request");

endmodule

/* rtl/fetch_packet_builder.sv */
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module fetch_packet_builder (
    input  logic [`LINE_BITS-1:0]    line,
    input  logic [31:0]              line_pc,

    output fetch_pkg::fetch_packet_t packet
);

    localparam int BLK_BYTES     = `FETCH_WIDTH * 4;
    localparam int BLK_OFF       = $clog2(BLK_BYTES);
    localparam int LINE_WORDS    = `LINE_BITS / 32;
    localparam int LINE_OFF      = $clog2(`LINE_BITS / 8);
    localparam int WORD_IDX_BITS = LINE_OFF - 2;

    logic [LINE_WORDS-1:0][31:0]  words;
    logic [WORD_IDX_BITS-1:0]     word_idx;
    logic [WORD_IDX_BITS-1:0]     blk_base;     // First word of the block.
    logic [BLK_OFF-3:0]           slot_off;
    logic [31:0]                  blk_pc;

    assign words    = line;
    assign word_idx = line_pc[LINE_OFF-1:2];
    assign blk_base = word_idx & ~WORD_IDX_BITS'(`FETCH_WIDTH - 1);
    assign slot_off = line_pc[BLK_OFF-1:2];       // Entry slot in the block.
    assign blk_pc   = line_pc & ~32'(BLK_BYTES - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packet fields. No predictor, so every target falls through.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        packet.pc            = blk_pc;
        packet.predict_taken = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            packet.inst[i]           = words[int'(blk_base) + i];
            packet.predict_target[i] = blk_pc + 32'(4 * i + 4);
            packet.slot_valid[i]     = (i >= int'(slot_off));
        end
    end

endmodule

/* rtl/frontend_top.sv */
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module frontend_top (
    input  logic                     clk,
    input  logic                     prev_rst,

    // Backend redirect.
    input  logic                     backend_flush,
    input  logic [31:0]              backend_redirect_pc,

    // Instruction cache.
    output fetch_pkg::icache_req_t   icache_req,
    input  fetch_pkg::icache_rsp_t   icache_rsp,

    // Fetch FIFO.
    output logic                     fifo_valid,
    input  logic                     fifo_ready,
    output fetch_pkg::fetch_packet_t fifo_packet
);

    logic [31:0]           pc_next;
    logic                  advance;         // Packet taken by the FIFO.
    logic [`LINE_BITS-1:0] line;
    logic [31:0]           line_pc;

    fetch_pc_gen i_pc_gen (
        .clk         (clk),
        .prev_rst    (prev_rst),
        .flush       (backend_flush),
        .redirect_pc (backend_redirect_pc),
        .advance     (advance),
        .pc_next     (pc_next)
    );

    fetch_line_reader i_line_reader (
        .clk         (clk),
        .prev_rst    (prev_rst),
        .flush       (backend_flush),
        .pc_next     (pc_next),
        .icache_req  (icache_req),
        .icache_rsp  (icache_rsp),
        .advance     (advance),
        .out_valid   (fifo_valid),
        .out_ready   (fifo_ready),
        .line        (line),
        .line_pc     (line_pc)
    );

    fetch_packet_builder i_packet_builder (
        .line        (line),
        .line_pc     (line_pc),
        .packet      (fifo_packet)
    );

endmodule

/* verification/icache_model.sv */
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module icache_model (
    input  logic                   clk,
    input  logic                   prev_rst,

    input  fetch_pkg::icache_req_t icache_req,
    output fetch_pkg::icache_rsp_t icache_rsp,

    // Answer after latency_sel + 1 cycles.
    input  logic [1:0]             latency_sel
);

    localparam int LINE_WORDS = `LINE_BITS / 32;

    logic        pending;
    logic [1:0]  wait_cnt;
    logic [31:0] line_addr;

    // Every word holds its own byte address.
    function automatic logic [`LINE_BITS-1:0] line_data(input logic [31:0] addr);
        logic [LINE_WORDS-1:0][31:0] words;
        for (int k = 0; k < LINE_WORDS; k++) begin
            words[k] = addr + 32'(4 * k);
        end
        return words;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One request at a time, answered with a single resp pulse.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            pending    <= 1'b0;
            wait_cnt   <= 2'd0;
            line_addr  <= '0;
            icache_rsp <= '0;
        end else begin
            icache_rsp.resp <= 1'b0;                 // Pulse lasts one cycle.
            if (pending) begin
                if (wait_cnt == 2'd0) begin
                    icache_rsp.resp  <= 1'b1;
                    icache_rsp.rdata <= line_data(line_addr);
                    pending          <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (icache_req.read) begin
                line_addr <= icache_req.addr;
                if (latency_sel == 2'd0) begin
                    icache_rsp.resp  <= 1'b1;        // Next-cycle answer.
                    icache_rsp.rdata <= line_data(icache_req.addr);
                end else begin
                    pending  <= 1'b1;
                    wait_cnt <= latency_sel - 2'd1;
                end
            end
        end
    end

endmodule

/* verification/frontend_tb.sv */
`timescale 1ns/10ps

`include "fetch_cfg.svh"

module frontend_tb;

    localparam int          BLK_BYTES      = `FETCH_WIDTH * 4;
    localparam int          LINE_OFF       = $clog2(`LINE_BITS / 8);
    localparam int          TIMEOUT_CYCLES = 4000;   // 112 packets, 6 cycles each, x5.
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;

    logic                          clk;
    logic                          prev_rst;
    logic                          backend_flush;
    logic [31:0]                   backend_redirect_pc;
    fetch_pkg::icache_req_t        icache_req;
    fetch_pkg::icache_rsp_t        icache_rsp;
    logic                          fifo_valid;
    logic                          fifo_ready;
    fetch_pkg::fetch_packet_t      fifo_packet;
    logic [1:0]                    cache_latency;

    logic [31:0]                   lfsr;
    logic [31:0]                   exp_pc;          // Next block the FIFO must see.
    logic [31:0]                   exp_blk;
    int                            exp_off;
    logic [`FETCH_WIDTH-1:0]       exp_mask;
    logic [`FETCH_WIDTH-1:0][31:0] exp_inst;
    logic [`FETCH_WIDTH-1:0][31:0] exp_target;
    logic                          xfer;
    int                            xfer_count;
    int                            cycle_count  = 0;
    int                            fail_count   = 0;
    int                            tests_passed = 0;
    int                            tests_failed = 0;

    frontend_top i_dut (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .icache_req          (icache_req),
        .icache_rsp          (icache_rsp),
        .fifo_valid          (fifo_valid),
        .fifo_ready          (fifo_ready),
        .fifo_packet         (fifo_packet)
    );

    icache_model i_icache (
        .clk         (clk),
        .prev_rst    (prev_rst),
        .icache_req  (icache_req),
        .icache_rsp  (icache_rsp),
        .latency_sel (cache_latency)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Expected packet model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign xfer = fifo_valid && fifo_ready;

    always_comb begin
        exp_blk = exp_pc & ~32'(BLK_BYTES - 1);
        exp_off = int'(exp_pc & 32'(BLK_BYTES - 1)) / 4;    // Entry slot.
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            exp_inst[i]   = exp_blk + 32'(4 * i);
            exp_target[i] = exp_blk + 32'(4 * i + 4);
            exp_mask[i]   = (i >= exp_off);
        end
    end

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            exp_pc     <= `RESET_VECTOR;
            xfer_count <= 0;
        end else if (backend_flush) begin
            exp_pc <= backend_redirect_pc;
        end else if (xfer) begin
            exp_pc     <= exp_blk + 32'(BLK_BYTES);
            xfer_count <= xfer_count + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_first_packet: assert property (@(posedge clk) disable iff (prev_rst)
        (xfer && xfer_count == 0) |->
            (fifo_packet.pc == `RESET_VECTOR && &fifo_packet.slot_valid)
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_packet.pc: got %h expected %h, slot_valid %h",
                 $sampled(fifo_packet.pc), `RESET_VECTOR, $sampled(fifo_packet.slot_valid));
    end

    a_block_pc: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |-> fifo_packet.pc == exp_blk
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_packet.pc: got %h expected %h",
                 $sampled(fifo_packet.pc), $sampled(exp_blk));
    end

    a_slot_mask: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |-> fifo_packet.slot_valid == exp_mask
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_packet.slot_valid: got %h expected %h",
                 $sampled(fifo_packet.slot_valid), $sampled(exp_mask));
    end

    a_inst_words: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |-> fifo_packet.inst == exp_inst
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_packet.inst: got %h expected %h",
                 $sampled(fifo_packet.inst), $sampled(exp_inst));
    end

    a_targets: assert property (@(posedge clk) disable iff (prev_rst)
        xfer |-> (fifo_packet.predict_target == exp_target && fifo_packet.predict_taken == '0)
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_packet.predict_target: got %h expected %h, taken %h",
                 $sampled(fifo_packet.predict_target), $sampled(exp_target),
                 $sampled(fifo_packet.predict_taken));
    end

    a_hold: assert property (@(posedge clk) disable iff (prev_rst)
        (fifo_valid && !fifo_ready && !backend_flush) |=>
            (backend_flush || (fifo_valid && $stable(fifo_packet)))
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_valid/fifo_packet under back-pressure: valid %h pc %h",
                 $sampled(fifo_valid), $sampled(fifo_packet.pc));
    end

    a_flush_drop: assert property (@(posedge clk) disable iff (prev_rst)
        backend_flush |-> !fifo_valid
    ) else begin
        fail_count++;
        $display("CHECK FAILED fifo_valid: got %h expected 0 in a flush cycle",
                 $sampled(fifo_valid));
    end

    a_line_aligned: assert property (@(posedge clk) disable iff (prev_rst)
        icache_req.read |-> icache_req.addr[LINE_OFF-1:0] == '0
    ) else begin
        fail_count++;
        $display("CHECK FAILED icache_req.addr: got %h, not line aligned",
                 $sampled(icache_req.addr));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_cycle(input logic random_ready, input logic flush_now);
        logic [31:0] r;
        @(posedge clk);
        r = random_bits(2);
        cache_latency <= r[1:0];
        if (random_ready) begin
            r = random_bits(1);
            fifo_ready <= r[0];
        end else begin
            fifo_ready <= 1'b1;
        end
        backend_flush <= flush_now;
        if (flush_now) begin
            r = random_bits(10);
            backend_redirect_pc <= `RESET_VECTOR + {r[29:0], 2'b00};   // Any word.
        end
    endtask

    task automatic run_packets(input int count, input logic random_ready);
        int target;
        target = xfer_count + count;
        while (xfer_count < target) begin
            drive_cycle(random_ready, 1'b0);
        end
    endtask

    task automatic run_flushes(input int count);
        logic [31:0] r;
        int          target;
        for (int n = 0; n < count; n++) begin
            r = random_bits(3);
            repeat (int'(r[2:0])) drive_cycle(1'b1, 1'b0);
            drive_cycle(1'b1, 1'b1);
            drive_cycle(1'b1, 1'b0);
            target = xfer_count + 1;         // First packet after the redirect.
            while (xfer_count < target) begin
                drive_cycle(1'b1, 1'b0);
            end
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d check failures", name, fail_count - fails_before);
        end
    endtask

    initial begin
        int fails_before;
        lfsr                = 32'hda32;
        prev_rst            = 1'b1;
        backend_flush       = 1'b0;
        backend_redirect_pc = '0;
        fifo_ready          = 1'b0;
        cache_latency       = 2'd0;
        repeat (2) @(posedge clk);
        prev_rst <= 1'b0;

        fails_before = fail_count;
        run_packets(40, 1'b0);
        report_test("reset and sequential fetch, 40 packets", fails_before);

        fails_before = fail_count;
        run_packets(60, 1'b1);
        report_test("random back-pressure, 60 packets", fails_before);

        fails_before = fail_count;
        run_flushes(12);
        report_test("random flushes, 12 redirects", fails_before);

        drive_cycle(1'b0, 1'b0);
        $display("tests passed %0d, tests failed %0d, check failures %0d",
                 tests_passed, tests_failed, fail_count);
        if (tests_failed == 0 && fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the tests.",
                     cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_line_reader.sv
rtl/fetch_packet_builder.sv
rtl/frontend_top.sv
verification/icache_model.sv
verification/frontend_tb.sv

/* Makefile */
# Verilator simulation of the fetch frontend.

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the frontend testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module frontend_tb
	@out="$$(./obj_dir/Vfrontend_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
